// File: Bender.yml
package:
  name: rv_core

sources:
  - source/rv_core_pkg.sv
  - source/rv_decoder.sv
  - source/rv_regfile.sv
  - source/rv_execute.sv
  - source/rv_result.sv
  - source/rv_core_top.sv
  - target: test
    files:
      - dv/rv_clock_gen.sv
      - dv/rv_core_tb.sv

// File: dv/rv_clock_gen.sv
// Testbench clock and reset source, period 10 with rst_n held low for 8 rising edges
`default_nettype none

module rv_clock_gen (
  output logic global_bus,
  output logic rst_n
);

  initial begin
    global_bus = 1'b0;
    forever #5 global_bus = ~global_bus;
  end

  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge global_bus);
    rst_n <= 1'b1;  // Released on the 8th edge
  end

endmodule

`default_nettype wire

// File: dv/rv_core_tb.sv
// Testbench for the RV32I back end, applies a table of instructions and checks each retire
`default_nettype none

module rv_core_tb;

  typedef struct packed {
    rv_core_pkg::instr_t   instr;
    rv_core_pkg::xlen_t    address;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::xlen_t    value;
    logic                  writes;
    logic                  jump_taken;
    rv_core_pkg::xlen_t    target;
    logic                  mem_access;
    logic                  mem_store;
    logic                  trap;
  } entry_t;

  logic                 global_bus;
  logic                 rst_n;
  logic                 stop;
  logic                 instr_valid;
  rv_core_pkg::instr_t  instr;
  rv_core_pkg::xlen_t   address;
  rv_core_pkg::result_t retire;

  entry_t entries[$];
  int     retired = 0;

  rv_clock_gen rv_clock_gen_inst (
    .global_bus (global_bus),
    .rst_n      (rst_n)
  );

  rv_core_top rv_core_top_inst (
    .global_bus  (global_bus),
    .rst_n       (rst_n),
    .stop        (stop),
    .instr_valid (instr_valid),
    .instr       (instr),
    .address     (address),
    .retire      (retire)
  );

  function automatic rv_core_pkg::instr_t r_type(int f3, int f7, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_core_pkg::op_op};
  endfunction

  function automatic rv_core_pkg::instr_t i_type(rv_core_pkg::opcode_t op, int f3, int rd,
                                                  int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rv_core_pkg::instr_t s_type(int f3, int rs1, int rs2, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_core_pkg::op_store};
  endfunction

  function automatic rv_core_pkg::instr_t b_type(int f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_core_pkg::op_branch};
  endfunction

  function automatic rv_core_pkg::instr_t u_type(rv_core_pkg::opcode_t op, int rd, int imm);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic rv_core_pkg::instr_t j_type(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_core_pkg::op_jal};
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic word_check(input int idx, input string field, input rv_core_pkg::xlen_t got,
                            input rv_core_pkg::xlen_t exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at time %0t: entry %0d %s is %h, expected %h",
                         $time, idx, field, got, exp));
  endtask

  task automatic index_check(input int idx, input string field,
                             input rv_core_pkg::reg_idx_t got, input rv_core_pkg::reg_idx_t exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at time %0t: entry %0d %s is x%0d, expected x%0d",
                         $time, idx, field, got, exp));
  endtask

  task automatic flag_check(input int idx, input string field, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at time %0t: entry %0d %s is %b, expected %b",
                         $time, idx, field, got, exp));
  endtask

  task automatic compare_retire(input int idx, input rv_core_pkg::result_t got, input entry_t exp);
    word_check(idx, "address", got.address, exp.address);
    index_check(idx, "rd", got.rd, exp.rd);
    word_check(idx, "value", got.value, exp.value);
    flag_check(idx, "write", got.writes & (got.rd != '0), exp.writes);  // Reaches the regfile
    flag_check(idx, "jump_taken", got.jump_taken, exp.jump_taken);
    word_check(idx, "target", got.target, exp.target);
    flag_check(idx, "mem_access", got.mem_access, exp.mem_access);
    flag_check(idx, "mem_store", got.mem_store, exp.mem_store);
    flag_check(idx, "trap", got.trap, exp.trap);
  endtask

  task automatic add_entry(input rv_core_pkg::instr_t word, input int rd,
                           input rv_core_pkg::xlen_t value, input int writes, input int jump,
                           input rv_core_pkg::xlen_t target, input int mem, input int trap);
    entry_t e;
    e.instr      = word;
    e.address    = rv_core_pkg::xlen_t'(32'h100 + 4 * entries.size());  // Sequential PCs
    e.rd         = rv_core_pkg::reg_idx_t'(rd);
    e.value      = value;
    e.writes     = (writes != 0);
    e.jump_taken = (jump != 0);
    e.target     = target;
    e.mem_access = (mem != 0);
    e.mem_store  = (mem == 2);  // 1 marks a load, 2 a store
    e.trap       = (trap != 0);
    entries.push_back(e);
  endtask

  task automatic build_table();
    add_entry(i_type(rv_core_pkg::op_imm, 0, 1, 0, 5), 1, 'h5, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 0, 2, 0, -3), 2, 'hFFFFFFFD, 1, 0, 0, 0, 0);
    add_entry(u_type(rv_core_pkg::op_lui, 3, 'h80000), 3, 'h80000000, 1, 0, 0, 0, 0);
    add_entry(r_type(0, 0, 4, 1, 2), 4, 'h2, 1, 0, 0, 0, 0);
    add_entry(r_type(0, 'h20, 5, 4, 1), 5, 'hFFFFFFFD, 1, 0, 0, 0, 0);  // SUB on bypass
    add_entry(r_type(2, 0, 6, 5, 1), 6, 'h1, 1, 0, 0, 0, 0);
    add_entry(r_type(3, 0, 7, 5, 1), 7, 'h0, 1, 0, 0, 0, 0);
    add_entry(r_type(5, 'h20, 8, 3, 1), 8, 'hFC000000, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 5, 9, 3, 'h404), 9, 'hF8000000, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 5, 10, 3, 31), 10, 'h1, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 1, 11, 1, 3), 11, 'h28, 1, 0, 0, 0, 0);
    add_entry(r_type(5, 0, 12, 5, 1), 12, 'h07FFFFFF, 1, 0, 0, 0, 0);
    add_entry(r_type(1, 0, 13, 1, 1), 13, 'hA0, 1, 0, 0, 0, 0);
    add_entry(r_type(4, 0, 14, 1, 2), 14, 'hFFFFFFF8, 1, 0, 0, 0, 0);
    add_entry(r_type(6, 0, 15, 1, 4), 15, 'h7, 1, 0, 0, 0, 0);
    add_entry(r_type(7, 0, 16, 2, 1), 16, 'h5, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 2, 17, 2, -1), 17, 'h1, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 3, 18, 1, -1), 18, 'h1, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 4, 19, 1, 'hFF), 19, 'hFA, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 6, 20, 1, 'h700), 20, 'h705, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 7, 21, 2, 'hF0), 21, 'hF0, 1, 0, 0, 0, 0);
    add_entry(u_type(rv_core_pkg::op_auipc, 22, 'h12345), 22, 'h12345154, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 0, 0, 1, 7), 0, 'hC, 0, 0, 0, 0, 0);  // x0 target
    add_entry(r_type(0, 0, 23, 0, 1), 23, 'h5, 1, 0, 0, 0, 0);
    add_entry(u_type(rv_core_pkg::op_lui, 0, 'hABCDE), 0, 'hABCDE000, 0, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 0, 24, 0, 1), 24, 'h1, 1, 0, 0, 0, 0);
    add_entry(b_type(0, 5, 2, 16), 0, 0, 0, 1, 'h178, 0, 0);
    add_entry(b_type(0, 1, 2, 8), 0, 0, 0, 0, 'h174, 0, 0);
    add_entry(b_type(1, 1, 2, -16), 0, 0, 0, 1, 'h160, 0, 0);
    add_entry(b_type(1, 5, 2, 32), 0, 0, 0, 0, 'h194, 0, 0);
    add_entry(b_type(4, 2, 1, 12), 0, 0, 0, 1, 'h184, 0, 0);
    add_entry(b_type(4, 1, 2, 12), 0, 0, 0, 0, 'h188, 0, 0);
    add_entry(b_type(5, 1, 2, -8), 0, 0, 0, 1, 'h178, 0, 0);
    add_entry(b_type(5, 2, 1, 4), 0, 0, 0, 0, 'h188, 0, 0);
    add_entry(b_type(6, 1, 2, 64), 0, 0, 0, 1, 'h1C8, 0, 0);
    add_entry(b_type(6, 2, 1, 64), 0, 0, 0, 0, 'h1CC, 0, 0);
    add_entry(b_type(7, 2, 1, -32), 0, 0, 0, 1, 'h170, 0, 0);
    add_entry(b_type(7, 4, 1, 20), 0, 0, 0, 0, 'h1A8, 0, 0);
    add_entry(j_type(25, 'h800), 25, 'h19C, 1, 1, 'h998, 0, 0);
    add_entry(i_type(rv_core_pkg::op_jalr, 0, 26, 1, 'h100), 26, 'h1A0, 1, 1, 'h104, 0, 0);
    add_entry(i_type(rv_core_pkg::op_jalr, 0, 27, 26, 3), 27, 'h1A4, 1, 1, 'h1A2, 0, 0);
    add_entry(j_type(0, -420), 0, 'h1A8, 0, 1, 'h0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_load, 2, 28, 27, 8), 28, 'h1AC, 0, 0, 0, 1, 0);
    add_entry(s_type(2, 22, 1, -4), 0, 'h12345150, 0, 0, 0, 2, 0);
    add_entry(s_type(0, 3, 2, -2048), 0, 'h7FFFF800, 0, 0, 0, 2, 0);
    add_entry(i_type(rv_core_pkg::op_load, 4, 29, 1, -1), 29, 'h4, 0, 0, 0, 1, 0);
    add_entry(r_type(0, 0, 30, 28, 1), 30, 'h5, 1, 0, 0, 0, 0);  // Load left x28 at zero
    add_entry(s_type(1, 2, 1, 6), 0, 'h3, 0, 0, 0, 2, 0);
    add_entry(i_type(rv_core_pkg::op_load, 1, 31, 4, 2), 31, 'h4, 0, 0, 0, 1, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 0, 10, 0, 'h123), 10, 'h123, 1, 0, 0, 0, 0);
    add_entry(i_type(rv_core_pkg::op_imm, 0, 10, 10, 1), 10, 'h124, 1, 0, 0, 0, 0);
    add_entry(r_type(0, 0, 11, 10, 10), 11, 'h248, 1, 0, 0, 0, 0);
    add_entry(r_type(0, 'h20, 12, 11, 10), 12, 'h124, 1, 0, 0, 0, 0);
    add_entry(s_type(2, 12, 12, 0), 0, 'h124, 0, 0, 0, 2, 0);
    add_entry(b_type(0, 12, 10, 8), 0, 0, 0, 1, 'h1E0, 0, 0);
    add_entry('h0FF0000F, 0, 0, 0, 0, 0, 0, 0);  // FENCE
    add_entry('h00000073, 0, 0, 0, 0, 0, 0, 1);
    add_entry('h00100073, 0, 0, 0, 0, 0, 0, 1);
    add_entry('h00000000, 0, 0, 0, 0, 0, 0, 1);
    add_entry(i_type(rv_core_pkg::op_load, 3, 5, 1, 0), 0, 0, 0, 0, 0, 0, 1);  // Bad funct3
    add_entry(i_type(rv_core_pkg::op_imm, 0, 6, 5, 0), 6, 'hFFFFFFFD, 1, 0, 0, 0, 0);
  endtask

  initial begin : stimulus
    int wait_cyc;
    stop        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    address     = '0;
    void'($urandom(60780));
    build_table();
    for (wait_cyc = 0; wait_cyc < 20 && rst_n !== 1'b1; wait_cyc++) @(posedge global_bus);
    if (rst_n !== 1'b1) fail_run("Reset was never released");
    foreach (entries[k]) begin
      instr_valid <= 1'b1;
      instr       <= entries[k].instr;
      address     <= entries[k].address;
      stop        <= ($urandom % 4) == 0;
      @(posedge global_bus);
      // Held until an edge samples stop low
      for (wait_cyc = 0; stop && wait_cyc < 30; wait_cyc++) begin
        stop <= ($urandom % 4) == 0;
        @(posedge global_bus);
      end
      if (stop) fail_run($sformatf("Stop stayed high for 30 cycles at entry %0d", k));
    end
    instr_valid <= 1'b0;
    stop        <= 1'b0;
    for (wait_cyc = 0; wait_cyc < 20 && retired < entries.size(); wait_cyc++)
      @(posedge global_bus);
    if (retired < entries.size())
      fail_run($sformatf("Timeout, no retire arrived for entry %0d", retired));
    repeat (5) @(posedge global_bus);  // Window for stray retires
    if (retired == entries.size()) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run($sformatf("Retired %0d results for %0d entries", retired, entries.size()));
    end
  end

  always @(posedge global_bus) begin
    if (rst_n === 1'b1 && retire.valid === 1'b1) begin
      if (retired >= entries.size())
        fail_run($sformatf("An extra retire arrived at time %0t", $time));
      else
        compare_retire(retired, retire, entries[retired]);
      retired <= retired + 1;
    end
  end

endmodule

`default_nettype wire

// File: source/rv_core_pkg.sv
// Shared widths, opcodes, instruction enums and stage structs for the RV32I back end
`default_nettype none

package rv_core_pkg;

  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] xlen_t;  // Data word, address or immediate
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  localparam xlen_t reset_address = '0;

  // Major opcode groups, instr[6:0]
  localparam opcode_t op_load     = 7'b0000011;
  localparam opcode_t op_store    = 7'b0100011;
  localparam opcode_t op_branch   = 7'b1100011;
  localparam opcode_t op_jalr     = 7'b1100111;
  localparam opcode_t op_misc_mem = 7'b0001111;
  localparam opcode_t op_jal      = 7'b1101111;
  localparam opcode_t op_imm      = 7'b0010011;
  localparam opcode_t op_op       = 7'b0110011;
  localparam opcode_t op_system   = 7'b1110011;
  localparam opcode_t op_auipc    = 7'b0010111;
  localparam opcode_t op_lui      = 7'b0110111;

  typedef enum logic [5:0] {
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    JAL, JALR,
    LUI, AUIPC,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    ECALL, EBREAK,
    UNKNOWN
  } instr_name_e;

  typedef enum logic [1:0] {
    LS,  // Load and store
    BR,  // Branch and jump
    AL,  // Arithmetic, logic, upper immediate
    SY   // System and undecodable
  } instr_type_e;

  typedef struct packed {
    logic        valid;
    xlen_t       address;
    xlen_t       immediate;
    reg_idx_t    rd;
    reg_idx_t    rs_1;
    reg_idx_t    rs_2;
    instr_name_e instr_name;
    instr_type_e instr_type;
    logic        writes;
    logic        jumps;
    logic        uses_imm;
    logic        accesses_mem;
  } decoded_t;

  typedef struct packed {
    logic     valid;
    xlen_t    address;
    reg_idx_t rd;
    xlen_t    value;       // Written data, link or effective address
    logic     writes;
    logic     jump_taken;
    xlen_t    target;
    logic     mem_access;
    logic     mem_store;
    logic     trap;
  } result_t;

endpackage

`default_nettype wire

// File: source/rv_core_top.sv
// Top level of the RV32I back end, wires decode, execute, result stage and register file
`default_nettype none

module rv_core_top (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  logic                 stop,
  input  logic                 instr_valid,
  input  rv_core_pkg::instr_t  instr,
  input  rv_core_pkg::xlen_t   address,
  output rv_core_pkg::result_t retire
);

  rv_core_pkg::decoded_t decoded;
  rv_core_pkg::result_t  ex_result;
  rv_core_pkg::reg_idx_t rs_1_idx;
  rv_core_pkg::reg_idx_t rs_2_idx;
  rv_core_pkg::xlen_t    rs_1_data;
  rv_core_pkg::xlen_t    rs_2_data;
  logic                  write;

  rv_decoder rv_decoder_inst (
    .global_bus  (global_bus),
    .rst_n       (rst_n),
    .stop        (stop),
    .instr_valid (instr_valid),
    .instr       (instr),
    .address     (address),
    .decoded     (decoded)
  );

  rv_execute rv_execute_inst (
    .decoded   (decoded),
    .rs_1      (rs_1_idx),
    .rs_2      (rs_2_idx),
    .rs_1_data (rs_1_data),
    .rs_2_data (rs_2_data),
    .bypass    (retire),
    .result    (ex_result)
  );

  rv_result rv_result_inst (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .stop       (stop),
    .result_in  (ex_result),
    .retire     (retire),
    .write      (write)
  );

  rv_regfile rv_regfile_inst (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .rs_1       (rs_1_idx),
    .rs_2       (rs_2_idx),
    .rs_1_data  (rs_1_data),
    .rs_2_data  (rs_2_data),
    .write      (write),
    .rd         (retire.rd),
    .rd_data    (retire.value)
  );

endmodule

`default_nettype wire

// File: source/rv_decoder.sv
// Decode stage, registers names, class, register indices, immediate and flags per strobe
`default_nettype none

module rv_decoder (
  input  logic                  global_bus,
  input  logic                  rst_n,
  input  logic                  stop,
  input  logic                  instr_valid,
  input  rv_core_pkg::instr_t   instr,
  input  rv_core_pkg::xlen_t    address,
  output rv_core_pkg::decoded_t decoded
);

  rv_core_pkg::opcode_t  opcode;
  logic [2:0]            funct3;
  logic                  funct7_alt;
  rv_core_pkg::xlen_t    imm_i;
  rv_core_pkg::xlen_t    imm_s;
  rv_core_pkg::xlen_t    imm_b;
  rv_core_pkg::xlen_t    imm_j;
  rv_core_pkg::xlen_t    imm_u;
  rv_core_pkg::xlen_t    imm_sh;
  rv_core_pkg::decoded_t next;

  assign opcode     = instr[6:0];
  assign funct3     = instr[14:12];
  assign funct7_alt = instr[30];  // SUB, SRA, SRAI

  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u  = {instr[31:12], 12'h000};
  assign imm_sh = {27'd0, instr[24:20]};  // Zero-extended shamt

  always_comb begin
    next            = '0;
    next.valid      = instr_valid;
    next.address    = address;
    next.rd         = instr[11:7];
    next.rs_1       = instr[19:15];
    next.rs_2       = instr[24:20];
    next.instr_name = rv_core_pkg::UNKNOWN;
    next.instr_type = rv_core_pkg::SY;
    case (opcode)
      rv_core_pkg::op_load: begin
        next.instr_type   = rv_core_pkg::LS;
        next.immediate    = imm_i;
        next.rs_2         = '0;
        next.writes       = 1'b1;
        next.uses_imm     = 1'b1;
        next.accesses_mem = 1'b1;
        case (funct3)
          3'b000:  next.instr_name = rv_core_pkg::LB;
          3'b001:  next.instr_name = rv_core_pkg::LH;
          3'b010:  next.instr_name = rv_core_pkg::LW;
          3'b100:  next.instr_name = rv_core_pkg::LBU;
          3'b101:  next.instr_name = rv_core_pkg::LHU;
          default: next.instr_name = rv_core_pkg::UNKNOWN;
        endcase
      end
      rv_core_pkg::op_store: begin
        next.instr_type   = rv_core_pkg::LS;
        next.immediate    = imm_s;
        next.rd           = '0;
        next.uses_imm     = 1'b1;
        next.accesses_mem = 1'b1;
        case (funct3)
          3'b000:  next.instr_name = rv_core_pkg::SB;
          3'b001:  next.instr_name = rv_core_pkg::SH;
          3'b010:  next.instr_name = rv_core_pkg::SW;
          default: next.instr_name = rv_core_pkg::UNKNOWN;
        endcase
      end
      rv_core_pkg::op_branch: begin
        next.instr_type = rv_core_pkg::BR;
        next.immediate  = imm_b;
        next.rd         = '0;
        next.jumps      = 1'b1;
        case (funct3)
          3'b000:  next.instr_name = rv_core_pkg::BEQ;
          3'b001:  next.instr_name = rv_core_pkg::BNE;
          3'b100:  next.instr_name = rv_core_pkg::BLT;
          3'b101:  next.instr_name = rv_core_pkg::BGE;
          3'b110:  next.instr_name = rv_core_pkg::BLTU;
          3'b111:  next.instr_name = rv_core_pkg::BGEU;
          default: next.instr_name = rv_core_pkg::UNKNOWN;
        endcase
      end
      rv_core_pkg::op_jalr: begin
        next.instr_type = rv_core_pkg::BR;
        next.immediate  = imm_i;
        next.rs_2       = '0;
        next.writes     = 1'b1;
        next.jumps      = 1'b1;
        next.uses_imm   = 1'b1;
        if (funct3 == 3'b000) next.instr_name = rv_core_pkg::JALR;
      end
      rv_core_pkg::op_jal: begin
        next.instr_type = rv_core_pkg::BR;
        next.immediate  = imm_j;
        next.rs_1       = '0;
        next.rs_2       = '0;
        next.writes     = 1'b1;
        next.jumps      = 1'b1;
        next.uses_imm   = 1'b1;
        next.instr_name = rv_core_pkg::JAL;
      end
      rv_core_pkg::op_misc_mem: begin
        // FENCE retires as ADDI x0, x0, 0
        next.instr_type = rv_core_pkg::AL;
        next.rd         = '0;
        next.rs_1       = '0;
        next.rs_2       = '0;
        next.uses_imm   = 1'b1;
        if (funct3 == 3'b000) next.instr_name = rv_core_pkg::ADDI;
      end
      rv_core_pkg::op_imm: begin
        next.instr_type = rv_core_pkg::AL;
        next.immediate  = (funct3[1:0] == 2'b01) ? imm_sh : imm_i;
        next.rs_2       = '0;
        next.writes     = 1'b1;
        next.uses_imm   = 1'b1;
        case (funct3)
          3'b000: next.instr_name = rv_core_pkg::ADDI;
          3'b010: next.instr_name = rv_core_pkg::SLTI;
          3'b011: next.instr_name = rv_core_pkg::SLTIU;
          3'b100: next.instr_name = rv_core_pkg::XORI;
          3'b110: next.instr_name = rv_core_pkg::ORI;
          3'b111: next.instr_name = rv_core_pkg::ANDI;
          3'b001: next.instr_name = rv_core_pkg::SLLI;
          3'b101: next.instr_name = funct7_alt ? rv_core_pkg::SRAI : rv_core_pkg::SRLI;
          default: next.instr_name = rv_core_pkg::UNKNOWN;
        endcase
      end
      rv_core_pkg::op_op: begin
        next.instr_type = rv_core_pkg::AL;
        next.writes     = 1'b1;
        case (funct3)
          3'b000: next.instr_name = funct7_alt ? rv_core_pkg::SUB : rv_core_pkg::ADD;
          3'b001: next.instr_name = rv_core_pkg::SLL;
          3'b010: next.instr_name = rv_core_pkg::SLT;
          3'b011: next.instr_name = rv_core_pkg::SLTU;
          3'b100: next.instr_name = rv_core_pkg::XOR;
          3'b101: next.instr_name = funct7_alt ? rv_core_pkg::SRA : rv_core_pkg::SRL;
          3'b110: next.instr_name = rv_core_pkg::OR;
          3'b111: next.instr_name = rv_core_pkg::AND;
          default: next.instr_name = rv_core_pkg::UNKNOWN;
        endcase
      end
      rv_core_pkg::op_system: begin
        if (instr[31:21] == '0 && instr[19:7] == '0)
          next.instr_name = instr[20] ? rv_core_pkg::EBREAK : rv_core_pkg::ECALL;
      end
      rv_core_pkg::op_auipc, rv_core_pkg::op_lui: begin
        next.instr_type = rv_core_pkg::AL;
        next.immediate  = imm_u;
        next.rs_1       = '0;
        next.rs_2       = '0;
        next.writes     = 1'b1;
        next.uses_imm   = 1'b1;
        next.instr_name = opcode[5] ? rv_core_pkg::LUI : rv_core_pkg::AUIPC;
      end
      default: next.instr_name = rv_core_pkg::UNKNOWN;
    endcase

    if (next.instr_name == rv_core_pkg::UNKNOWN) begin  // Includes the all-zero word
      next.instr_type   = rv_core_pkg::SY;
      next.rd           = '0;
      next.writes       = 1'b0;
      next.jumps        = 1'b0;
      next.uses_imm     = 1'b0;
      next.accesses_mem = 1'b0;
    end
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      decoded.valid        <= 1'b0;
      decoded.address      <= rv_core_pkg::reset_address;
      decoded.writes       <= 1'b0;
      decoded.jumps        <= 1'b0;
      decoded.uses_imm     <= 1'b0;
      decoded.accesses_mem <= 1'b0;
    end else if (!stop) begin
      if (instr_valid) decoded <= next;
      else decoded.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/rv_execute.sv
// Execute stage, combinational ALU, branch compare and address math with result bypass
`default_nettype none

module rv_execute (
  input  rv_core_pkg::decoded_t decoded,
  output rv_core_pkg::reg_idx_t rs_1,
  output rv_core_pkg::reg_idx_t rs_2,
  input  rv_core_pkg::xlen_t    rs_1_data,
  input  rv_core_pkg::xlen_t    rs_2_data,
  input  rv_core_pkg::result_t  bypass,
  output rv_core_pkg::result_t  result
);

  logic               bypass_ok;
  logic               cond;
  logic [4:0]         shamt;
  rv_core_pkg::xlen_t op_a;
  rv_core_pkg::xlen_t op_reg_b;
  rv_core_pkg::xlen_t op_b;
  rv_core_pkg::xlen_t alu_value;
  rv_core_pkg::xlen_t link;
  rv_core_pkg::xlen_t pc_rel;
  rv_core_pkg::xlen_t reg_rel;

  assign rs_1 = decoded.rs_1;
  assign rs_2 = decoded.rs_2;

  // Result stage holds the previous instruction, not yet in the register file
  assign bypass_ok = bypass.valid & bypass.writes & (bypass.rd != '0);
  assign op_a      = (bypass_ok && bypass.rd == decoded.rs_1) ? bypass.value : rs_1_data;
  assign op_reg_b  = (bypass_ok && bypass.rd == decoded.rs_2) ? bypass.value : rs_2_data;
  assign op_b      = decoded.uses_imm ? decoded.immediate : op_reg_b;

  assign shamt   = op_b[4:0];
  assign link    = decoded.address + 32'd4;
  assign pc_rel  = decoded.address + decoded.immediate;
  assign reg_rel = op_a + decoded.immediate;  // Load/store address, JALR target

  always_comb begin
    case (decoded.instr_name)
      rv_core_pkg::ADD, rv_core_pkg::ADDI: alu_value = op_a + op_b;
      rv_core_pkg::SUB: alu_value = op_a - op_b;
      rv_core_pkg::SLL, rv_core_pkg::SLLI: alu_value = op_a << shamt;
      rv_core_pkg::SLT, rv_core_pkg::SLTI:
        alu_value = rv_core_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      rv_core_pkg::SLTU, rv_core_pkg::SLTIU: alu_value = rv_core_pkg::xlen_t'(op_a < op_b);
      rv_core_pkg::XOR, rv_core_pkg::XORI: alu_value = op_a ^ op_b;
      rv_core_pkg::OR, rv_core_pkg::ORI: alu_value = op_a | op_b;
      rv_core_pkg::AND, rv_core_pkg::ANDI: alu_value = op_a & op_b;
      rv_core_pkg::SRL, rv_core_pkg::SRLI: alu_value = op_a >> shamt;
      rv_core_pkg::SRA, rv_core_pkg::SRAI: alu_value = $signed(op_a) >>> shamt;
      rv_core_pkg::LUI: alu_value = decoded.immediate;
      rv_core_pkg::AUIPC: alu_value = pc_rel;
      default: alu_value = '0;
    endcase
  end

  always_comb begin
    case (decoded.instr_name)
      rv_core_pkg::BEQ: cond = (op_a == op_reg_b);
      rv_core_pkg::BNE: cond = (op_a != op_reg_b);
      rv_core_pkg::BLT: cond = ($signed(op_a) < $signed(op_reg_b));
      rv_core_pkg::BGE: cond = ($signed(op_a) >= $signed(op_reg_b));
      rv_core_pkg::BLTU: cond = (op_a < op_reg_b);
      rv_core_pkg::BGEU: cond = (op_a >= op_reg_b);
      rv_core_pkg::JAL, rv_core_pkg::JALR: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    result         = '0;
    result.valid   = decoded.valid;
    result.address = decoded.address;
    result.rd      = decoded.rd;
    result.writes  = decoded.writes;
    if (decoded.valid) begin
      case (decoded.instr_type)
        rv_core_pkg::LS: begin
          result.value      = reg_rel;
          result.mem_access = decoded.accesses_mem;
          result.mem_store  = decoded.instr_name inside
                              {rv_core_pkg::SB, rv_core_pkg::SH, rv_core_pkg::SW};
          result.writes     = 1'b0;  // No data memory behind loads
        end
        rv_core_pkg::BR: begin
          result.jump_taken = decoded.jumps & cond;
          if (decoded.instr_name == rv_core_pkg::JALR) result.target = {reg_rel[31:1], 1'b0};
          else result.target = pc_rel;
          if (decoded.writes) result.value = link;
        end
        rv_core_pkg::AL: result.value = alu_value;
        rv_core_pkg::SY: begin  // ECALL, EBREAK, undecodable
          result.trap   = 1'b1;
          result.writes = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
// Integer register file with x0 hardwired to zero, two async reads and one write port
`default_nettype none

module rv_regfile (
  input  logic                  global_bus,
  input  logic                  rst_n,
  input  rv_core_pkg::reg_idx_t rs_1,
  input  rv_core_pkg::reg_idx_t rs_2,
  output rv_core_pkg::xlen_t    rs_1_data,
  output rv_core_pkg::xlen_t    rs_2_data,
  input  logic                  write,
  input  rv_core_pkg::reg_idx_t rd,
  input  rv_core_pkg::xlen_t    rd_data
);

  rv_core_pkg::xlen_t regs [1:31];  // No storage for x0

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs_1_data = (rs_1 == '0) ? '0 : regs[rs_1];
  assign rs_2_data = (rs_2 == '0) ? '0 : regs[rs_2];

endmodule

`default_nettype wire

// File: source/rv_result.sv
// Result stage, registers the execute output and drives retire and the register write
`default_nettype none

module rv_result (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  logic                 stop,
  input  rv_core_pkg::result_t result_in,
  output rv_core_pkg::result_t retire,
  output logic                 write
);

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      retire.valid      <= 1'b0;
      retire.address    <= rv_core_pkg::reset_address;
      retire.writes     <= 1'b0;
      retire.jump_taken <= 1'b0;
      retire.mem_access <= 1'b0;
      retire.mem_store  <= 1'b0;
      retire.trap       <= 1'b0;
    end else if (stop) begin
      retire.valid <= 1'b0;  // Hold payload, retire once only
    end else begin
      retire <= result_in;
    end
  end

  // Register file takes the value on the edge after retire shows it
  assign write = retire.valid & retire.writes & (retire.rd != '0);

endmodule

`default_nettype wire

// File: vlog.f
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core_top.sv
dv/rv_clock_gen.sv
dv/rv_core_tb.sv
